// File: source/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// byte address and instruction widths
`define FETCH_ADDR_W 32
`define FETCH_WORD_W 32

// cache geometry, index is addr[9:2], tag is addr[31:10]
`define FETCH_IDX_W 8
`define FETCH_TAG_W 22
`define FETCH_LINES 256

// instruction memory
`define FETCH_MEM_WORDS 1024
`define FETCH_MEM_LAT 3

`endif

// File: source/fetch_pkg.sv
`include "fetch_consts.svh"

package fetch_pkg;

  // upstream request payload
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] pc;
  } fetch_req_t;

  // downstream payload, hit set when served from the cache
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_WORD_W-1:0] inst;
    logic                     hit;
  } fetch_resp_t;

  // read bus
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] addr;
  } mem_rd_req_t;

  typedef struct packed {
    logic [`FETCH_WORD_W-1:0] data;
  } mem_rd_resp_t;

  // program load write
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] addr;
    logic [`FETCH_WORD_W-1:0] data;
  } mem_wr_t;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_LOOKUP,
    FS_MISS,
    FS_RESP
  } fetch_state_e;

endpackage

// File: source/icache.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module icache (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     lookup_en_i,
  input  logic [`FETCH_ADDR_W-1:0] lookup_addr_i,
  input  logic                     flush_i,
  input  logic                     fill_en_i,
  input  logic [`FETCH_ADDR_W-1:0] fill_addr_i,
  input  logic [`FETCH_WORD_W-1:0] fill_data_i,
  output logic                     hit_o,
  output logic [`FETCH_WORD_W-1:0] rd_data_o
);

  logic [`FETCH_WORD_W-1:0] data_mem [`FETCH_LINES];
  logic [`FETCH_TAG_W-1:0]  tag_mem  [`FETCH_LINES];
  logic [`FETCH_LINES-1:0]  valid_q;

  logic [`FETCH_IDX_W-1:0]  lk_idx;
  logic [`FETCH_TAG_W-1:0]  lk_tag;
  logic [`FETCH_IDX_W-1:0]  fill_idx;
  logic [`FETCH_TAG_W-1:0]  fill_tag;
  logic                     lk_match;

  // index sits right above the byte offset, tag takes the rest
  assign lk_idx   = lookup_addr_i[`FETCH_IDX_W+1:2];
  assign lk_tag   = lookup_addr_i[`FETCH_ADDR_W-1:`FETCH_ADDR_W-`FETCH_TAG_W];
  assign fill_idx = fill_addr_i[`FETCH_IDX_W+1:2];
  assign fill_tag = fill_addr_i[`FETCH_ADDR_W-1:`FETCH_ADDR_W-`FETCH_TAG_W];

  assign lk_match = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);

  // valid bits, flush wins over a fill in the same cycle
  always_ff @(posedge clk)
    begin
      if (rst)
        begin
          valid_q <= '0;
        end
      else if (flush_i)
        begin
          valid_q <= '0;
        end
      else if (fill_en_i)
        begin
          valid_q[fill_idx] <= 1'b1;
        end
    end

  // line data and tag
  always_ff @(posedge clk)
    begin
      if (fill_en_i)
        begin
          data_mem[fill_idx] <= fill_data_i;
          tag_mem[fill_idx]  <= fill_tag;
        end
    end

  // registered lookup result
  always_ff @(posedge clk)
    begin
      if (rst)
        begin
          hit_o <= 1'b0;
        end
      else if (lookup_en_i)
        begin
          hit_o <= lk_match;
        end
    end

  always_ff @(posedge clk)
    begin
      if (lookup_en_i)
        begin
          rd_data_o <= data_mem[lk_idx];
        end
    end

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req_valid_i,
  input  fetch_pkg::fetch_req_t   req_i,
  output logic                    req_ready_o,
  output logic                    resp_valid_o,
  output fetch_pkg::fetch_resp_t  resp_o,
  input  logic                    resp_ready_i,
  input  logic                    flush_i,
  output logic                    mem_arvalid_o,
  output fetch_pkg::mem_rd_req_t  mem_req_o,
  input  logic                    mem_rvalid_i,
  input  fetch_pkg::mem_rd_resp_t mem_resp_i
);

  fetch_pkg::fetch_state_e  state;
  fetch_pkg::fetch_resp_t   resp_q;
  logic [`FETCH_ADDR_W-1:0] pc_q;
  logic                     lk_phase;
  logic                     arvalid_q;

  logic                     req_fire;
  logic                     lookup_en;
  logic                     lookup_done;
  logic                     fill_en;
  logic                     cache_hit;
  logic [`FETCH_WORD_W-1:0] cache_data;

  assign req_ready_o  = (state == fetch_pkg::FS_IDLE);
  assign req_fire     = req_valid_i && req_ready_o;

  // first lookup cycle drives the cache, second one reads its result
  assign lookup_en    = (state == fetch_pkg::FS_LOOKUP) && !lk_phase;
  assign lookup_done  = (state == fetch_pkg::FS_LOOKUP) && lk_phase;
  assign fill_en      = (state == fetch_pkg::FS_MISS) && mem_rvalid_i;

  assign resp_valid_o  = (state == fetch_pkg::FS_RESP);
  assign resp_o        = resp_q;
  assign mem_arvalid_o = arvalid_q;
  assign mem_req_o.addr = pc_q;

  icache u_icache (
    .clk           (clk),
    .rst           (rst),
    .lookup_en_i   (lookup_en),
    .lookup_addr_i (pc_q),
    .flush_i       (flush_i),
    .fill_en_i     (fill_en),
    .fill_addr_i   (pc_q),
    .fill_data_i   (mem_resp_i.data),
    .hit_o         (cache_hit),
    .rd_data_o     (cache_data)
  );

  always_ff @(posedge clk)
    begin
      if (rst)
        begin
          state     <= fetch_pkg::FS_IDLE;
          lk_phase  <= 1'b0;
          arvalid_q <= 1'b0;
        end
      else
        begin
          // bus request is a single cycle pulse
          arvalid_q <= 1'b0;
          case (state)
            fetch_pkg::FS_IDLE:
              begin
                if (req_valid_i)
                  begin
                    state    <= fetch_pkg::FS_LOOKUP;
                    lk_phase <= 1'b0;
                  end
              end
            fetch_pkg::FS_LOOKUP:
              begin
                if (!lk_phase)
                  begin
                    lk_phase <= 1'b1;
                  end
                else if (cache_hit)
                  begin
                    state <= fetch_pkg::FS_RESP;
                  end
                else
                  begin
                    state     <= fetch_pkg::FS_MISS;
                    arvalid_q <= 1'b1;
                  end
              end
            fetch_pkg::FS_MISS:
              begin
                if (mem_rvalid_i)
                  begin
                    state <= fetch_pkg::FS_RESP;
                  end
              end
            fetch_pkg::FS_RESP:
              begin
                // hold until downstream takes it
                if (resp_ready_i)
                  begin
                    state <= fetch_pkg::FS_IDLE;
                  end
              end
            default:
              begin
                state <= fetch_pkg::FS_IDLE;
              end
          endcase
        end
    end

  always_ff @(posedge clk)
    begin
      if (req_fire)
        begin
          pc_q <= req_i.pc;
        end
      if (lookup_done && cache_hit)
        begin
          resp_q.pc   <= pc_q;
          resp_q.inst <= cache_data;
          resp_q.hit  <= 1'b1;
        end
      else if (fill_en)
        begin
          resp_q.pc   <= pc_q;
          resp_q.inst <= mem_resp_i.data;
          resp_q.hit  <= 1'b0;
        end
    end

endmodule

// File: source/imem_sram.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module imem_sram (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    arvalid_i,
  input  fetch_pkg::mem_rd_req_t  rd_req_i,
  output logic                    rvalid_o,
  output fetch_pkg::mem_rd_resp_t rd_resp_o,
  input  logic                    we_i,
  input  fetch_pkg::mem_wr_t      wr_i
);

  localparam int IDX_W = $clog2(`FETCH_MEM_WORDS);
  localparam int LAT   = `FETCH_MEM_LAT;

  logic [`FETCH_WORD_W-1:0]          mem [`FETCH_MEM_WORDS];
  logic [LAT-1:0]                    vld_pipe;
  logic [LAT-1:0][`FETCH_WORD_W-1:0] data_pipe;

  logic [IDX_W-1:0]                  rd_idx;
  logic [IDX_W-1:0]                  wr_idx;

  // word addressed
  assign rd_idx = rd_req_i.addr[IDX_W+1:2];
  assign wr_idx = wr_i.addr[IDX_W+1:2];

  always_ff @(posedge clk)
    begin
      if (we_i)
        begin
          mem[wr_idx] <= wr_i.data;
        end
    end

  // valid travels with the data down the pipe
  always_ff @(posedge clk)
    begin
      if (rst)
        begin
          vld_pipe <= '0;
        end
      else
        begin
          vld_pipe <= {vld_pipe[LAT-2:0], arvalid_i};
        end
    end

  // array read on the request edge, so a same-edge write is not seen
  always_ff @(posedge clk)
    begin
      data_pipe[0] <= mem[rd_idx];
      for (int i = 1; i < LAT; i++)
        begin
          data_pipe[i] <= data_pipe[i-1];
        end
    end

  assign rvalid_o       = vld_pipe[LAT-1];
  assign rd_resp_o.data = data_pipe[LAT-1];

endmodule

// File: source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_valid_i,
  input  fetch_pkg::fetch_req_t  req_i,
  output logic                   req_ready_o,
  output logic                   resp_valid_o,
  output fetch_pkg::fetch_resp_t resp_o,
  input  logic                   resp_ready_i,
  input  logic                   flush_i,
  input  logic                   mem_we_i,
  input  fetch_pkg::mem_wr_t     mem_wr_i
);

  logic                    mem_arvalid;
  fetch_pkg::mem_rd_req_t  mem_rd_req;
  logic                    mem_rvalid;
  fetch_pkg::mem_rd_resp_t mem_rd_resp;

  fetch_unit u_fetch_unit (
    .clk           (clk),
    .rst           (rst),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o),
    .resp_ready_i  (resp_ready_i),
    .flush_i       (flush_i),
    .mem_arvalid_o (mem_arvalid),
    .mem_req_o     (mem_rd_req),
    .mem_rvalid_i  (mem_rvalid),
    .mem_resp_i    (mem_rd_resp)
  );

  imem_sram u_imem_sram (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (mem_arvalid),
    .rd_req_i  (mem_rd_req),
    .rvalid_o  (mem_rvalid),
    .rd_resp_o (mem_rd_resp),
    .we_i      (mem_we_i),
    .wr_i      (mem_wr_i)
  );

endmodule

// File: tests/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_tb;

  localparam int TIMEOUT   = 100;
  localparam int MEM_IDX_W = $clog2(`FETCH_MEM_WORDS);

  typedef enum logic [1:0] {
    OP_FETCH,
    OP_WRITE,
    OP_FLUSH
  } tb_op_e;

  // one stimulus step with its expected hit bit
  typedef struct packed {
    tb_op_e                   op;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_WORD_W-1:0] data;
    logic [7:0]               stall;
    logic                     exp_hit;
  } stim_entry_t;

  logic                   clk;
  logic                   rst;
  logic                   req_valid_i;
  fetch_pkg::fetch_req_t  req_i;
  logic                   req_ready_o;
  logic                   resp_valid_o;
  fetch_pkg::fetch_resp_t resp_o;
  logic                   resp_ready_i;
  logic                   flush_i;
  logic                   mem_we_i;
  fetch_pkg::mem_wr_t     mem_wr_i;

  // shadow memory and reference cache model
  logic [`FETCH_WORD_W-1:0] shadow    [`FETCH_MEM_WORDS];
  logic                     ref_valid [`FETCH_LINES];
  logic [`FETCH_TAG_W-1:0]  ref_tag   [`FETCH_LINES];
  logic [`FETCH_WORD_W-1:0] ref_data  [`FETCH_LINES];

  stim_entry_t stim_q [$];
  logic [31:0] rng;

  fetch_top dut (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .resp_ready_i (resp_ready_i),
    .flush_i      (flush_i),
    .mem_we_i     (mem_we_i),
    .mem_wr_i     (mem_wr_i)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_val(input logic [127:0] actual, input logic [127:0] expected,
                           input string msg);
    if (actual !== expected)
      begin
        $display("FAIL at %0t: %s, got %h expected %h", $time, msg, actual, expected);
        $display("TB FAILED");
        $fatal(1, "value mismatch");
      end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s, fetch FSM in state %s", what,
             dut.u_fetch_unit.state.name());
    $display("TB FAILED");
    $fatal(1, "handshake timeout");
  endtask

  task automatic mem_write(input logic [`FETCH_ADDR_W-1:0] addr,
                           input logic [`FETCH_WORD_W-1:0] data);
    mem_we_i      = 1'b1;
    mem_wr_i.addr = addr;
    mem_wr_i.data = data;
    @(negedge clk);
    mem_we_i = 1'b0;
    shadow[addr[MEM_IDX_W+1:2]] = data;
  endtask

  task automatic cache_flush();
    int i;
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    for (i = 0; i < `FETCH_LINES; i++)
      begin
        ref_valid[i] = 1'b0;
      end
  endtask

  task automatic fetch_and_check(input logic [`FETCH_ADDR_W-1:0] pc,
                                 input logic [7:0] stall, input logic exp_hit);
    int                       cnt;
    int                       i;
    logic [`FETCH_IDX_W-1:0]  idx;
    logic [`FETCH_TAG_W-1:0]  tag;
    logic                     model_hit;
    logic [`FETCH_WORD_W-1:0] exp_inst;
    fetch_pkg::fetch_resp_t   held;
    idx = pc[`FETCH_IDX_W+1:2];
    tag = pc[`FETCH_ADDR_W-1:`FETCH_ADDR_W-`FETCH_TAG_W];
    model_hit = ref_valid[idx] && (ref_tag[idx] == tag);
    if (model_hit)
      begin
        exp_inst = ref_data[idx];
      end
    else
      begin
        // a miss refills the line from memory
        exp_inst       = shadow[pc[MEM_IDX_W+1:2]];
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
        ref_data[idx]  = exp_inst;
      end
    req_valid_i = 1'b1;
    req_i.pc    = pc;
    cnt = 0;
    while (!req_ready_o)
      begin
        @(negedge clk);
        cnt++;
        if (cnt > TIMEOUT)
          report_timeout("req_ready_o");
      end
    @(negedge clk);
    req_valid_i = 1'b0;
    req_i       = '0;
    cnt = 0;
    while (!resp_valid_o)
      begin
        @(negedge clk);
        cnt++;
        if (cnt > TIMEOUT)
          report_timeout("resp_valid_o");
      end
    held = resp_o;
    // response must hold under back-pressure
    for (i = 0; i < stall; i++)
      begin
        @(negedge clk);
        check_val(resp_valid_o, 1'b1, "resp_valid_o dropped under back-pressure");
        check_val(resp_o, held, "response changed under back-pressure");
        check_val(req_ready_o, 1'b0, "req_ready_o high under back-pressure");
      end
    check_val(resp_o.pc, pc, "response pc");
    check_val(resp_o.inst, exp_inst, "response inst");
    check_val(resp_o.hit, model_hit, "hit bit against cache model");
    check_val(resp_o.hit, exp_hit, "hit bit against table");
    resp_ready_i = 1'b1;
    @(negedge clk);
    resp_ready_i = 1'b0;
  endtask

  task automatic add_entry(input tb_op_e op, input logic [`FETCH_ADDR_W-1:0] pc,
                           input logic [`FETCH_WORD_W-1:0] data, input logic [7:0] stall,
                           input logic exp_hit);
    stim_entry_t e;
    e.op      = op;
    e.pc      = pc;
    e.data    = data;
    e.stall   = stall;
    e.exp_hit = exp_hit;
    stim_q.push_back(e);
  endtask

  initial
    begin
      clk          = 1'b0;
      rst          = 1'b1;
      req_valid_i  = 1'b0;
      req_i        = '0;
      resp_ready_i = 1'b0;
      flush_i      = 1'b0;
      mem_we_i     = 1'b0;
      mem_wr_i     = '0;
      rng          = 32'h68f2_2c8a;
      for (int i = 0; i < `FETCH_LINES; i++)
        begin
          ref_valid[i] = 1'b0;
        end
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // program load
      for (int i = 0; i < `FETCH_MEM_WORDS; i++)
        begin
          rng = xorshift32(rng);
          mem_write(i * 4, rng);
        end

      // cold miss, then hit
      add_entry(OP_FETCH, 32'h0000_0100, '0, 8'd0, 1'b0);
      add_entry(OP_FETCH, 32'h0000_0100, '0, 8'd0, 1'b1);
      // same index with tags 1 KiB apart
      add_entry(OP_FETCH, 32'h0000_0040, '0, 8'd0, 1'b0);
      add_entry(OP_FETCH, 32'h0000_0440, '0, 8'd0, 1'b0);
      add_entry(OP_FETCH, 32'h0000_0040, '0, 8'd0, 1'b0);
      add_entry(OP_FETCH, 32'h0000_0440, '0, 8'd0, 1'b0);
      // stale line until fence.i style flush
      add_entry(OP_FETCH, 32'h0000_0200, '0, 8'd0, 1'b0);
      add_entry(OP_WRITE, 32'h0000_0200, 32'hc0de_0200, 8'd0, 1'b0);
      add_entry(OP_FETCH, 32'h0000_0200, '0, 8'd0, 1'b1);
      add_entry(OP_FLUSH, '0, '0, 8'd0, 1'b0);
      add_entry(OP_FETCH, 32'h0000_0200, '0, 8'd0, 1'b0);
      add_entry(OP_FETCH, 32'h0000_0200, '0, 8'd0, 1'b1);
      // stalled miss and stalled hit
      add_entry(OP_FETCH, 32'h0000_0300, '0, 8'd5, 1'b0);
      add_entry(OP_FETCH, 32'h0000_0300, '0, 8'd4, 1'b1);
      // sequential run gives all misses then all hits
      add_entry(OP_FLUSH, '0, '0, 8'd0, 1'b0);
      for (int pass = 0; pass < 2; pass++)
        begin
          for (int i = 0; i < 64; i++)
            begin
              add_entry(OP_FETCH, 32'h0000_0800 + i * 4, '0, 8'd0, pass == 1);
            end
        end

      foreach (stim_q[n])
        begin
          case (stim_q[n].op)
            OP_FETCH:
              fetch_and_check(stim_q[n].pc, stim_q[n].stall, stim_q[n].exp_hit);
            OP_WRITE:
              mem_write(stim_q[n].pc, stim_q[n].data);
            default:
              cache_flush();
          endcase
        end

      $display("%0d table entries applied", stim_q.size());
      $display("TB PASSED");
      $finish;
    end

endmodule

// File: filelist.f
+incdir+source
source/fetch_pkg.sv
source/icache.sv
source/fetch_unit.sv
source/imem_sram.sv
source/fetch_top.sv
tests/fetch_tb.sv
